// ==== uart_pkg.sv ====
package uart_pkg;

   // Frame layout: start, eight data bits LSB first, odd parity, stop.
   localparam int frame_bits = 11;
   localparam int data_bits  = 8;

   typedef logic [data_bits-1:0]  byte_t;
   typedef logic [15:0]           cmd_t;
   typedef logic [frame_bits-1:0] frame_t;
   typedef logic [3:0]            bit_idx_t;

   // Result of one received frame.
   typedef struct packed {
      byte_t data;
      logic  parity_ok;
      logic  stop_ok;
   } rx_result_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_SHIFT,
      TX_ACK
   } tx_state_t;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_REQ,
      RX_DONE
   } rx_state_t;

   typedef enum logic [2:0] {
      C_IDLE,
      C_LO,
      C_LO_GAP,
      C_HI,
      C_HI_END
   } ctrl_state_t;

endpackage

// ==== uart_tx_frame.sv ====
`timescale 1ns/100ps

module uart_tx_frame import uart_pkg::*; #(
   parameter int clks_per_bit = 16
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  tx_req,
   input  byte_t tx_byte,
   output logic  tx_ack,
   output logic  tx
);

   localparam int cnt_w = $clog2(clks_per_bit);

   typedef logic [cnt_w-1:0] cnt_t;

   localparam cnt_t     cnt_last = cnt_t'(clks_per_bit - 1);
   localparam cnt_t     cnt_ack  = cnt_t'(clks_per_bit - 2);
   localparam bit_idx_t stop_idx = bit_idx_t'(frame_bits - 1);

   tx_state_t state;
   cnt_t      cnt;
   bit_idx_t  bit_idx;
   frame_t    shreg;
   logic      load;
   logic      shift;

   // Stop is bit 10, parity bit 9, data bits 8 to 1, start bit 0.
   function automatic frame_t make_frame(byte_t b);
      return {1'b1, ~^b, b, 1'b0};
   endfunction

   assign load   = (state == TX_IDLE) && tx_req;
   assign shift  = (state == TX_SHIFT) && (cnt == cnt_last) && (bit_idx != stop_idx);
   assign tx_ack = (state == TX_ACK);

   always_ff @(posedge clk) begin
      if (load) begin
         shreg <= make_frame(tx_byte);
      end else if (shift) begin
         shreg <= {1'b1, shreg[frame_bits-1:1]};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= TX_IDLE;
         tx      <= 1'b1;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (load) begin
                  tx      <= 1'b0;
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= TX_SHIFT;
               end
            end
            TX_SHIFT: begin
               // Ack goes up one cycle early, so ctrl samples it as the stop bit ends.
               if ((bit_idx == stop_idx) && (cnt == cnt_ack)) begin
                  state <= TX_ACK;
               end else if (cnt == cnt_last) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  tx      <= shreg[1];
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            TX_ACK: begin
               tx <= 1'b1;
               if (!tx_req) begin
                  state <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

endmodule

// ==== uart_rx_frame.sv ====
`timescale 1ns/100ps

module uart_rx_frame import uart_pkg::*; #(
   parameter int clks_per_bit = 16
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rx,
   output logic       rx_req,
   output rx_result_t rx_res,
   input  logic       rx_ack
);

   localparam int cnt_w = $clog2(clks_per_bit);

   typedef logic [cnt_w-1:0] cnt_t;

   localparam cnt_t     cnt_last = cnt_t'(clks_per_bit - 1);
   localparam cnt_t     cnt_half = cnt_t'(clks_per_bit / 2 - 1);
   localparam bit_idx_t stop_idx = bit_idx_t'(frame_bits - 1);

   rx_state_t            state;
   cnt_t                 cnt;
   bit_idx_t             bit_idx;
   logic                 rx_s1;
   logic                 rx_s2;
   logic [data_bits+1:0] shreg;
   logic [data_bits+1:0] shreg_nxt;
   logic                 sample;
   logic                 last_sample;

   // Data, parity and stop end up LSB first in the shift register.
   assign shreg_nxt   = {rx_s2, shreg[data_bits+1:1]};
   assign sample      = (state == RX_DATA) && (cnt == cnt_last);
   assign last_sample = sample && (bit_idx == stop_idx);
   assign rx_req      = (state == RX_REQ);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_s1 <= 1'b1;
         rx_s2 <= 1'b1;
      end else begin
         rx_s1 <= rx;
         rx_s2 <= rx_s1;
      end
   end

   always_ff @(posedge clk) begin
      if (sample) begin
         shreg <= shreg_nxt;
      end
      if (last_sample) begin
         rx_res.data      <= shreg_nxt[data_bits-1:0];
         rx_res.parity_ok <= ^shreg_nxt[data_bits:0];
         rx_res.stop_ok   <= shreg_nxt[data_bits+1];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               if (!rx_s2) begin
                  cnt   <= '0;
                  state <= RX_START;
               end
            end
            RX_START: begin
               // A start bit that is high again at its midpoint is a glitch.
               if (cnt == cnt_half) begin
                  cnt <= '0;
                  if (!rx_s2) begin
                     bit_idx <= bit_idx_t'(1);
                     state   <= RX_DATA;
                  end else begin
                     state <= RX_IDLE;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (sample) begin
                  cnt <= '0;
                  if (last_sample) begin
                     state <= RX_REQ;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_REQ: begin
               if (rx_ack) begin
                  state <= RX_DONE;
               end
            end
            RX_DONE: begin
               if (!rx_ack) begin
                  state <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

endmodule

// ==== uart_ctrl.sv ====
`timescale 1ns/100ps

module uart_ctrl import uart_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       cmd_vld,
   input  cmd_t       cmd,
   output logic       cmd_rdy,
   output logic       tx_req,
   output byte_t      tx_byte,
   input  logic       tx_ack,
   input  logic       rx_req,
   input  rx_result_t rx_res,
   output logic       rx_ack,
   output logic       read_rdy,
   output logic       read_err,
   output byte_t      read_data
);

   ctrl_state_t state;
   cmd_t        cmd_q;
   logic        rx_take;

   assign cmd_rdy = (state == C_IDLE);
   assign tx_req  = (state == C_LO) || (state == C_HI);
   assign tx_byte = (state == C_HI) ? cmd_q[15:8] : cmd_q[7:0];
   assign rx_take = rx_req && !rx_ack;

   always_ff @(posedge clk) begin
      if (cmd_rdy && cmd_vld) begin
         cmd_q <= cmd;
      end
      if (rx_take) begin
         read_data <= rx_res.data;
      end
   end

   // Low byte first, then high byte, each as one full req/ack cycle.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= C_IDLE;
      end else begin
         case (state)
            C_IDLE:   if (cmd_vld) state <= C_LO;
            C_LO:     if (tx_ack) state <= C_LO_GAP;
            C_LO_GAP: if (!tx_ack) state <= C_HI;
            C_HI:     if (tx_ack) state <= C_HI_END;
            C_HI_END: if (!tx_ack) state <= C_IDLE;
            default:  state <= C_IDLE;
         endcase
      end
   end

   // Receive side runs on its own, one pulse per result.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_ack   <= 1'b0;
         read_rdy <= 1'b0;
         read_err <= 1'b0;
      end else begin
         read_rdy <= 1'b0;
         read_err <= 1'b0;
         if (rx_take) begin
            rx_ack <= 1'b1;
            if (rx_res.parity_ok && rx_res.stop_ok) begin
               read_rdy <= 1'b1;
            end else begin
               read_err <= 1'b1;
            end
         end else if (!rx_req) begin
            rx_ack <= 1'b0;
         end
      end
   end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/100ps

module uart_top import uart_pkg::*; #(
   parameter int clks_per_bit = 16
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  cmd_vld,
   input  cmd_t  cmd,
   output logic  cmd_rdy,
   input  logic  rx,
   output logic  tx,
   output logic  read_rdy,
   output byte_t read_data,
   output logic  read_err
);

   logic       tx_req;
   logic       tx_ack;
   byte_t      tx_byte;
   logic       rx_req;
   logic       rx_ack;
   rx_result_t rx_res;

   uart_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_vld   (cmd_vld),
      .cmd       (cmd),
      .cmd_rdy   (cmd_rdy),
      .tx_req    (tx_req),
      .tx_byte   (tx_byte),
      .tx_ack    (tx_ack),
      .rx_req    (rx_req),
      .rx_res    (rx_res),
      .rx_ack    (rx_ack),
      .read_rdy  (read_rdy),
      .read_err  (read_err),
      .read_data (read_data)
   );

   uart_tx_frame #(
      .clks_per_bit (clks_per_bit)
   ) u_tx_frame (
      .clk     (clk),
      .rst_n   (rst_n),
      .tx_req  (tx_req),
      .tx_byte (tx_byte),
      .tx_ack  (tx_ack),
      .tx      (tx)
   );

   uart_rx_frame #(
      .clks_per_bit (clks_per_bit)
   ) u_rx_frame (
      .clk    (clk),
      .rst_n  (rst_n),
      .rx     (rx),
      .rx_req (rx_req),
      .rx_res (rx_res),
      .rx_ack (rx_ack)
   );

endmodule

// ==== uart_asserts.sv ====
`timescale 1ns/100ps

module uart_asserts (
   input logic clk,
   input logic rst_n,
   input logic cmd_rdy,
   input logic tx_req,
   input logic tx_ack,
   input logic read_rdy,
   input logic read_err
);

   int n_fail;

   // A request holds until the datapath answers.
   req_held: assert property (@(posedge clk) disable iff (!rst_n)
      tx_req && !tx_ack |=> tx_req)
      else begin
         $error("tx_req dropped before tx_ack");
         n_fail++;
      end

   ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(tx_ack) |-> tx_req)
      else begin
         $error("tx_ack rose without tx_req");
         n_fail++;
      end

   read_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(read_rdy && read_err))
      else begin
         $error("read_rdy and read_err high together");
         n_fail++;
      end

   // Busy until the datapath has dropped its last ack.
   busy_no_rdy: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_req || tx_ack) |-> !cmd_rdy)
      else begin
         $error("cmd_rdy high during a transmit");
         n_fail++;
      end

endmodule

bind uart_ctrl uart_asserts u_asserts (
   .clk      (clk),
   .rst_n    (rst_n),
   .cmd_rdy  (cmd_rdy),
   .tx_req   (tx_req),
   .tx_ack   (tx_ack),
   .read_rdy (read_rdy),
   .read_err (read_err)
);

// ==== uart_tb.sv ====
`timescale 1ns/100ps

module uart_tb import uart_pkg::*; ();

   localparam int cpb      = 4;
   localparam int n_fixed  = 7;
   localparam int n_rows   = n_fixed + 4;
   localparam int limit_ns = n_rows * 2 * frame_bits * cpb * 10 + 10000;

   typedef struct packed {
      logic inject;
      logic poke;
      logic flip_par;
      logic bad_stop;
      logic exp_err;
      cmd_t data;
   } row_t;

   logic       clk;
   logic       rst_n;
   logic       cmd_vld;
   cmd_t       cmd;
   logic       cmd_rdy;
   logic       rx;
   logic       tx;
   logic       read_rdy;
   byte_t      read_data;
   logic       read_err;
   logic       loop_sel;
   logic       rx_inj;
   row_t       rows [n_rows];
   string      row_name [n_rows];
   int         n_added;
   byte_t      got_data [$];
   int         got_err;
   logic [7:0] lfsr;

   // Loopback feeds tx back, otherwise the bit-banged line drives rx.
   assign rx = loop_sel ? tx : rx_inj;

   uart_top #(
      .clks_per_bit (cpb)
   ) UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_vld   (cmd_vld),
      .cmd       (cmd),
      .cmd_rdy   (cmd_rdy),
      .rx        (rx),
      .tx        (tx),
      .read_rdy  (read_rdy),
      .read_data (read_data),
      .read_err  (read_err)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(limit_ns);
      $display("Watchdog expired: the DUT stopped answering and the run hung.");
      $display("Done: errors found");
      $fatal(1, "timeout");
   end

   initial begin
      wait (UUT.u_ctrl.u_asserts.n_fail != 0);
      $display("A handshake assertion on the control module failed.");
      $display("Done: errors found");
      $fatal(1, "assertion");
   end

   // Galois form of x^8 + x^6 + x^5 + x^4 + 1.
   function automatic logic [7:0] lfsr_step(logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   function automatic frame_t expected_frame(byte_t b);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) ones += b[i];
      // Data plus parity must hold an odd number of ones.
      return {1'b1, (ones % 2 == 0), b, 1'b0};
   endfunction

   task automatic check(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("** Error: %s expected %h actual %h", name, exp, act);
         $display("Done: errors found");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic add_row(string name, logic inject, logic poke, logic flip_par,
                          logic bad_stop, logic exp_err, cmd_t data);
      rows[n_added]     = '{inject, poke, flip_par, bad_stop, exp_err, data};
      row_name[n_added] = name;
      n_added++;
   endtask

   task automatic build_table();
      cmd_t w;
      n_added = 0;
      // Name, inject, poke while busy, flip parity, low stop, expect error, data.
      add_row("loop_c3a5",      0, 0, 0, 0, 0, 16'hC3A5);
      add_row("loop_ff00",      0, 0, 0, 0, 0, 16'hFF00);
      add_row("loop_busy",      0, 1, 0, 0, 0, 16'h5A81);
      add_row("inj_good",       1, 0, 0, 0, 0, 16'h003C);
      add_row("inj_bad_parity", 1, 0, 1, 0, 1, 16'h0096);
      add_row("inj_bad_stop",   1, 0, 0, 1, 1, 16'h0047);
      add_row("inj_recover",    1, 0, 0, 0, 0, 16'h00E1);
      lfsr = 8'd22;
      for (int k = 0; k < n_rows - n_fixed; k++) begin
         for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
         end
         add_row($sformatf("lfsr_%0d", k), 0, 0, 0, 0, 0, w);
      end
   endtask

   task automatic drive_frame(byte_t b, logic flip, logic bad_stop);
      frame_t f;
      f     = expected_frame(b);
      f[9]  = f[9] ^ flip;
      f[10] = !bad_stop;
      @(posedge clk);
      #1;
      for (int i = 0; i < frame_bits; i++) begin
         rx_inj = f[i];
         repeat (cpb) @(posedge clk);
         #1;
      end
      rx_inj = 1'b1;
   endtask

   task automatic send_cmd(cmd_t c, logic poke);
      @(posedge clk);
      #1;
      cmd     = c;
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
      if (poke) begin
         // The block is busy here, so this command has to be dropped.
         repeat (10) @(posedge clk);
         #1;
         cmd     = ~c;
         cmd_vld = 1'b1;
         @(posedge clk);
         #1;
         cmd_vld = 1'b0;
      end
      while (!cmd_rdy) @(negedge clk);
   endtask

   task automatic capture_frame(string name, byte_t b);
      frame_t got;
      @(negedge tx);
      #21;
      for (int i = 0; i < frame_bits; i++) begin
         got[i] = tx;
         if (i < frame_bits - 1) #(cpb * 10);
      end
      check({name, " tx frame"}, expected_frame(b), got);
   endtask

   task automatic collect_reads(int n);
      while (got_data.size() + got_err < n) begin
         @(negedge clk);
         if (read_rdy) got_data.push_back(read_data);
         if (read_err) got_err++;
      end
   endtask

   initial begin
      row_t row;
      cmd_vld  = 1'b0;
      cmd      = '0;
      rx_inj   = 1'b1;
      loop_sel = 1'b1;
      rst_n    = 1'b0;
      build_table();
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check("reset tx", 1, tx);
      check("reset cmd_rdy", 1, cmd_rdy);
      check("reset read pulses", 0, {read_rdy, read_err});
      for (int r = 0; r < n_rows; r++) begin
         row      = rows[r];
         loop_sel = !row.inject;
         got_data.delete();
         got_err = 0;
         if (row.inject) begin
            fork
               drive_frame(row.data[7:0], row.flip_par, row.bad_stop);
               collect_reads(1);
            join
            check({row_name[r], " read_err"}, row.exp_err, got_err);
            check({row_name[r], " read_rdy"}, !row.exp_err, got_data.size());
            if (!row.exp_err) check({row_name[r], " data"}, row.data[7:0], got_data[0]);
         end else begin
            fork
               send_cmd(row.data, row.poke);
               begin
                  capture_frame(row_name[r], row.data[7:0]);
                  capture_frame(row_name[r], row.data[15:8]);
               end
               collect_reads(2);
            join
            check({row_name[r], " read_err"}, 0, got_err);
            check({row_name[r], " low byte"}, row.data[7:0], got_data[0]);
            check({row_name[r], " high byte"}, row.data[15:8], got_data[1]);
         end
         repeat (8) begin
            @(negedge clk);
            check({row_name[r], " quiet"}, 0, {read_rdy, read_err});
         end
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

// ==== sim.f ====
uart_pkg.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_ctrl.sv
uart_top.sv
uart_asserts.sv
uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart

sources:
  - uart_pkg.sv
  - uart_tx_frame.sv
  - uart_rx_frame.sv
  - uart_ctrl.sv
  - uart_top.sv
  - target: simulation
    files:
      - uart_asserts.sv
      - uart_tb.sv
